// File: verilog/gb_cart_pkg.sv
/*
 * cartridge side definitions: header locations, header codes, bank widths
 * header addresses are download word addresses, type byte is in the high half
 * only MBC1, MBC2, MBC3 and MBC5 are decoded, all other types map to mbc_none
 */

package gb_cart_pkg;

	// ------------------------------------------------------------------
	// download port
	localparam int dl_addr_w  = 24;            // word address
	localparam int dl_data_w  = 16;
	localparam int rom_data_w = 16;            // external ROM word

	// header words
	localparam logic [dl_addr_w-1:0] hdr_addr_type = 24'h000146; // type in [15:8]
	localparam logic [dl_addr_w-1:0] hdr_addr_size = 24'h000148; // ram [15:8], rom [7:0]

	// ------------------------------------------------------------------
	// bank widths
	localparam int rom_bank_w  = 9;            // up to 512 x 16k banks (MBC5)
	localparam int ram_bank_w  = 4;            // up to 16 x 8k banks
	localparam int rom_word_w  = 22;           // 8 MB of 16 bit words
	localparam int cram_addr_w = 17;           // 128 KB of byte RAM

	localparam logic [3:0] ram_enable_key = 4'ha;

	// header type code ranges per controller
	localparam logic [7:0] code_mbc1_lo = 8'h01;
	localparam logic [7:0] code_mbc1_hi = 8'h03;
	localparam logic [7:0] code_mbc2_lo = 8'h05;
	localparam logic [7:0] code_mbc2_hi = 8'h06;
	localparam logic [7:0] code_mbc3_lo = 8'h0f;
	localparam logic [7:0] code_mbc3_hi = 8'h13;
	localparam logic [7:0] code_mbc5_lo = 8'h19;
	localparam logic [7:0] code_mbc5_hi = 8'h1e;

	// size codes with special meaning
	localparam logic [7:0] rom_code_max = 8'h08; // 512 banks
	localparam logic [7:0] ram_code_32k = 8'h03; // 4 banks, above this 16 banks

	typedef enum logic [2:0] {
		mbc_none,
		mbc_1,
		mbc_2,
		mbc_3,
		mbc_5
	} mbc_kind_t;

endpackage

// File: verilog/gb_bus_pkg.sv
/*
 * CPU side bus definitions and the address window decode
 * write windows only exist below 8000, region decode uses addr[15:13]
 */

package gb_bus_pkg;

	localparam int cpu_addr_w = 16;
	localparam int cpu_data_w = 8;

	// register write windows inside ROM space, addr[14:13]
	typedef enum logic [1:0] {
		reg_ram_enable = 2'd0,                 // 0000-1fff
		reg_rom_bank   = 2'd1,                 // 2000-3fff
		reg_ram_bank   = 2'd2,                 // 4000-5fff
		reg_mode       = 2'd3                  // 6000-7fff
	} cart_wreg_t;

	// read regions
	typedef enum logic [1:0] {
		rom_bank0,                             // 0000-3fff
		rom_bankn,                             // 4000-7fff
		cram,                                  // a000-bfff
		other
	} cart_region_t;

	function automatic cart_region_t cpu_region(input logic [cpu_addr_w-1:0] addr);
		case (addr[15:13])
			3'b000, 3'b001: return rom_bank0;
			3'b010, 3'b011: return rom_bankn;
			3'b101:         return cram;
			default:        return other;
		endcase
	endfunction

	function automatic cart_wreg_t cpu_wreg(input logic [cpu_addr_w-1:0] addr);
		return cart_wreg_t'(addr[14:13]);      // only meaningful with addr[15] low
	endfunction

endpackage

// File: verilog/cart_header_capture.sv
/*
 * header bytes are taken from download words at fixed word addresses
 * masks are combinational from the latched codes, valid one cycle after dl_wr
 * cart_ready goes high the cycle after download ends, low while downloading
 */
`timescale 1ns/1ps

module cart_header_capture
	import gb_cart_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  dl_active,
	input  logic                  dl_wr,
	input  logic [dl_addr_w-1:0]  dl_addr,
	input  logic [dl_data_w-1:0]  dl_data,
	output mbc_kind_t             mbc_kind,
	output logic [rom_bank_w-1:0] rom_mask,
	output logic [ram_bank_w-1:0] ram_mask,
	output logic                  cart_ready
);

	logic [7:0] type_code;
	logic [7:0] rom_code;
	logic [7:0] ram_code;
	logic       dl_active_q;                   // for end of download detect

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			type_code   <= 8'h00;
			rom_code    <= 8'h00;
			ram_code    <= 8'h00;
			dl_active_q <= 1'b0;
			cart_ready  <= 1'b0;
		end else begin
			dl_active_q <= dl_active;
			if (dl_active && dl_wr) begin
				if (dl_addr == hdr_addr_type)
					type_code <= dl_data[15:8];
				if (dl_addr == hdr_addr_size) begin
					ram_code <= dl_data[15:8];
					rom_code <= dl_data[7:0];
				end
			end
			if (dl_active)
				cart_ready <= 1'b0;        // new image coming in
			else if (dl_active_q)
				cart_ready <= 1'b1;        // falling edge of download
		end
	end

	// ------------------------------------------------------------------
	// header decode
	always_comb begin
		if (type_code inside {[code_mbc1_lo:code_mbc1_hi]})      mbc_kind = mbc_1;
		else if (type_code inside {[code_mbc2_lo:code_mbc2_hi]}) mbc_kind = mbc_2;
		else if (type_code inside {[code_mbc3_lo:code_mbc3_hi]}) mbc_kind = mbc_3;
		else if (type_code inside {[code_mbc5_lo:code_mbc5_hi]}) mbc_kind = mbc_5;
		else                                                      mbc_kind = mbc_none;

		case (rom_code)
			8'd0:    rom_mask = 9'h001;        // 32k, direct mapped
			8'd1:    rom_mask = 9'h003;
			8'd2:    rom_mask = 9'h007;
			8'd3:    rom_mask = 9'h00f;
			8'd4:    rom_mask = 9'h01f;        // 512k
			8'd5:    rom_mask = 9'h03f;
			8'd6:    rom_mask = 9'h07f;
			8'd7:    rom_mask = 9'h0ff;
			8'd8:    rom_mask = 9'h1ff;        // rom_code_max, 8M
			default: rom_mask = 9'h07f;        // odd sizes 52-54 and junk
		endcase

		if (ram_code == ram_code_32k)     ram_mask = 4'b0011;
		else if (ram_code > ram_code_32k) ram_mask = 4'b1111;
		else                              ram_mask = 4'b0000; // none, 2k or 8k
	end

endmodule

// File: verilog/mbc_registers.sv
/*
 * controller registers written through ROM space stores (0000-7fff)
 * all registers sit at reset values while a download is running
 * writes apply on any edge with cpu_ce and cpu_wr high
 */
`timescale 1ns/1ps

module mbc_registers
	import gb_cart_pkg::*;
	import gb_bus_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  dl_active,
	input  logic                  cpu_ce,
	input  logic                  cpu_wr,
	input  logic [cpu_addr_w-1:0] cpu_addr,
	input  logic [cpu_data_w-1:0] cpu_wdata,
	input  mbc_kind_t             mbc_kind,
	output logic [rom_bank_w-1:0] rom_bank,
	output logic [ram_bank_w-1:0] ram_bank,
	output logic                  mbc1_mode,
	output logic                  rtc_sel,
	output logic                  ram_enable
);

	logic       reg_wr;
	cart_wreg_t wreg;

	assign reg_wr = cpu_ce && cpu_wr && (cpu_region(cpu_addr) inside {rom_bank0, rom_bankn});
	assign wreg   = cpu_wreg(cpu_addr);

	always_ff @(posedge clk_sys) begin
		if (reset || dl_active) begin
			rom_bank   <= 9'd1;            // bank 1 visible at 4000 after reset
			ram_bank   <= 4'd0;
			mbc1_mode  <= 1'b0;
			rtc_sel    <= 1'b0;
			ram_enable <= 1'b0;
		end else if (reg_wr) begin
			case (wreg)
				reg_ram_enable: ram_enable <= (cpu_wdata[3:0] == ram_enable_key);

				reg_rom_bank: begin
					if (mbc_kind == mbc_5) begin
						if (cpu_addr[12])
							rom_bank[8] <= cpu_wdata[0];     // 3000-3fff
						else
							rom_bank[7:0] <= cpu_wdata;      // 2000-2fff
					end else if (cpu_wdata[6:0] == 7'd0) begin
						rom_bank <= 9'd1;                    // bank 0 reads as 1
					end else begin
						rom_bank <= {2'b00, cpu_wdata[6:0]};
					end
				end

				reg_ram_bank: begin
					case (mbc_kind)
						mbc_3: begin
							if (cpu_wdata[3]) begin
								rtc_sel <= 1'b1;      // RTC register select
							end else begin
								rtc_sel  <= 1'b0;
								ram_bank <= {2'b00, cpu_wdata[1:0]};
							end
						end
						mbc_5:   ram_bank <= cpu_wdata[3:0];
						default: ram_bank <= {2'b00, cpu_wdata[1:0]};
					endcase
				end

				reg_mode: begin
					if (mbc_kind == mbc_1)
						mbc1_mode <= cpu_wdata[0];   // 1 = 4Mbit/32KB RAM mode
				end
			endcase
		end
	end

endmodule

// File: verilog/bank_mapper.sv
/*
 * pure combinational address map, CPU address to ROM word and CRAM byte
 * bank 0 region always maps bank 0, no controller means 32k linear ROM
 */
`timescale 1ns/1ps

module bank_mapper
	import gb_cart_pkg::*;
	import gb_bus_pkg::*;
(
	input  logic [cpu_addr_w-1:0]  cpu_addr,
	input  mbc_kind_t              mbc_kind,
	input  logic [rom_bank_w-1:0]  rom_bank,
	input  logic [ram_bank_w-1:0]  ram_bank,
	input  logic                   mbc1_mode,
	input  logic [rom_bank_w-1:0]  rom_mask,
	input  logic [ram_bank_w-1:0]  ram_mask,
	output logic [rom_word_w-1:0]  rom_addr,
	output logic [cram_addr_w-1:0] cram_addr
);

	logic [6:0]            mbc1_bank;        // mode 0 takes RAM bank as upper ROM bits
	logic [rom_bank_w-1:0] bank_n;           // bank seen at 4000-7fff
	logic [rom_bank_w-1:0] bank;
	logic [ram_bank_w-1:0] cbank;

	always_comb begin
		mbc1_bank = mbc1_mode ? {2'b00, rom_bank[4:0]} : {ram_bank[1:0], rom_bank[4:0]};

		case (mbc_kind)
			mbc_1:        bank_n = {2'b00, mbc1_bank} & rom_mask;
			mbc_2, mbc_3: bank_n = {2'b00, rom_bank[6:0]} & rom_mask;
			mbc_5:        bank_n = rom_bank & rom_mask;  // full 9 bits, bank 0 allowed
			default:      bank_n = 9'd1;                  // no controller
		endcase

		if (cpu_region(cpu_addr) == rom_bankn) bank = bank_n;
		else                                    bank = '0;

		// RAM banking
		case (mbc_kind)
			mbc_1:   cbank = mbc1_mode ? ({2'b00, ram_bank[1:0]} & ram_mask) : '0;
			mbc_2:   cbank = '0;                     // 512 x 4 bit, single bank
			default: cbank = ram_bank & ram_mask;
		endcase
	end

	assign rom_addr  = {bank, cpu_addr[13], cpu_addr[12:1]};
	assign cram_addr = {cbank, cpu_addr[12:0]};

endmodule

// File: verilog/cart_ram_port.sv
/*
 * 128 KB cartridge RAM plus the registered CPU read mux
 * cpu_rdata updates only on read edges and holds in between
 * RTC registers are not modelled, RTC select reads back 00
 */
`timescale 1ns/1ps

module cart_ram_port
	import gb_cart_pkg::*;
	import gb_bus_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   cpu_ce,
	input  logic                   cpu_rd,
	input  logic                   cpu_wr,
	input  logic [cpu_addr_w-1:0]  cpu_addr,
	input  logic [cpu_data_w-1:0]  cpu_wdata,
	input  logic [cram_addr_w-1:0] cram_addr,
	input  logic [rom_data_w-1:0]  rom_rdata,
	input  mbc_kind_t              mbc_kind,
	input  logic                   ram_enable,
	input  logic                   rtc_sel,
	input  logic                   cart_ready,
	output logic [cpu_data_w-1:0]  cpu_rdata
);

	logic [cpu_data_w-1:0] mem [0:(2**cram_addr_w)-1];

	logic                  in_cram;
	logic                  mbc2_nibble;      // a000-a1ff on MBC2 holds 4 bit cells
	logic [cpu_data_w-1:0] rom_byte;

	assign in_cram     = (cpu_region(cpu_addr) == cram);
	assign mbc2_nibble = (mbc_kind == mbc_2) && (cpu_addr[15:9] == 7'b1010000);
	assign rom_byte    = cpu_addr[0] ? rom_rdata[15:8] : rom_rdata[7:0];

	// storage, no reset
	always_ff @(posedge clk_sys) begin
		if (cpu_ce && cpu_wr && in_cram && ram_enable)
			mem[cram_addr] <= cpu_wdata;
	end

	// ------------------------------------------------------------------
	// read data, one result per read edge
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cpu_rdata <= 8'h00;
		end else if (cpu_ce && cpu_rd) begin
			if (!cart_ready)
				cpu_rdata <= 8'h00;                      // no image loaded yet
			else if (!in_cram)
				cpu_rdata <= rom_byte;
			else if (!ram_enable)
				cpu_rdata <= 8'hff;                      // open bus when disabled
			else if (mbc2_nibble)
				cpu_rdata <= {4'hf, mem[cram_addr][3:0]};
			else if (rtc_sel)
				cpu_rdata <= 8'h00;
			else
				cpu_rdata <= mem[cram_addr];
		end
	end

endmodule

// File: verilog/gb_cart_mapper.sv
/*
 * cartridge mapper top: header capture, MBC registers, address map, CRAM
 * the ROM sits outside, rom_rdata must follow rom_addr in the same cycle
 * one download word per dl_wr cycle, no back pressure
 */
`timescale 1ns/1ps

module gb_cart_mapper
	import gb_cart_pkg::*;
	import gb_bus_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  reset,
	// download
	input  logic                  dl_active,
	input  logic                  dl_wr,
	input  logic [dl_addr_w-1:0]  dl_addr,
	input  logic [dl_data_w-1:0]  dl_data,
	// CPU bus
	input  logic                  cpu_ce,
	input  logic                  cpu_rd,
	input  logic                  cpu_wr,
	input  logic [cpu_addr_w-1:0] cpu_addr,
	input  logic [cpu_data_w-1:0] cpu_wdata,
	output logic [cpu_data_w-1:0] cpu_rdata,
	// external ROM
	output logic [rom_word_w-1:0] rom_addr,
	input  logic [rom_data_w-1:0] rom_rdata
);

	mbc_kind_t              mbc_kind;
	logic [rom_bank_w-1:0]  rom_mask;
	logic [ram_bank_w-1:0]  ram_mask;
	logic                   cart_ready;
	logic [rom_bank_w-1:0]  rom_bank;
	logic [ram_bank_w-1:0]  ram_bank;
	logic                   mbc1_mode;
	logic                   rtc_sel;
	logic                   ram_enable;
	logic [cram_addr_w-1:0] cram_addr;

	cart_header_capture i_header (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl_active  (dl_active),
		.dl_wr      (dl_wr),
		.dl_addr    (dl_addr),
		.dl_data    (dl_data),
		.mbc_kind   (mbc_kind),
		.rom_mask   (rom_mask),
		.ram_mask   (ram_mask),
		.cart_ready (cart_ready)
	);

	mbc_registers i_regs (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl_active  (dl_active),
		.cpu_ce     (cpu_ce),
		.cpu_wr     (cpu_wr),
		.cpu_addr   (cpu_addr),
		.cpu_wdata  (cpu_wdata),
		.mbc_kind   (mbc_kind),
		.rom_bank   (rom_bank),
		.ram_bank   (ram_bank),
		.mbc1_mode  (mbc1_mode),
		.rtc_sel    (rtc_sel),
		.ram_enable (ram_enable)
	);

	bank_mapper i_map (
		.cpu_addr   (cpu_addr),
		.mbc_kind   (mbc_kind),
		.rom_bank   (rom_bank),
		.ram_bank   (ram_bank),
		.mbc1_mode  (mbc1_mode),
		.rom_mask   (rom_mask),
		.ram_mask   (ram_mask),
		.rom_addr   (rom_addr),
		.cram_addr  (cram_addr)
	);

	cart_ram_port i_cram (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cpu_ce     (cpu_ce),
		.cpu_rd     (cpu_rd),
		.cpu_wr     (cpu_wr),
		.cpu_addr   (cpu_addr),
		.cpu_wdata  (cpu_wdata),
		.cram_addr  (cram_addr),
		.rom_rdata  (rom_rdata),
		.mbc_kind   (mbc_kind),
		.ram_enable (ram_enable),
		.rtc_sel    (rtc_sel),
		.cart_ready (cart_ready),
		.cpu_rdata  (cpu_rdata)
	);

endmodule

// File: tb/gb_cart_mapper_assertions.sv
/*
 * concurrent checks bound into the mapper top, sampled on clk_sys
 * only bank bits of rom_addr are checked for the bank 0 window
 */
`timescale 1ns/1ps

module gb_cart_mapper_assertions
	import gb_cart_pkg::*;
	import gb_bus_pkg::*;
(
	input logic                  clk_sys,
	input logic                  reset,
	input logic                  dl_active,
	input logic                  cpu_ce,
	input logic                  cpu_rd,
	input logic [cpu_addr_w-1:0] cpu_addr,
	input logic [cpu_data_w-1:0] cpu_rdata,
	input logic [rom_word_w-1:0] rom_addr,
	input logic [rom_bank_w-1:0] rom_bank,
	input logic                  ram_enable,
	input logic                  cart_ready
);

	// no cartridge loaded, every read gives 00
	a_rdata_not_ready: assert property (@(posedge clk_sys) disable iff (reset)
		(cpu_ce && cpu_rd && !cart_ready) |=> (cpu_rdata == 8'h00))
		else $error("cpu_rdata not 00 after a read with no cartridge ready");

	// 0000-3fff always maps bank 0
	a_bank0_window: assert property (@(posedge clk_sys) disable iff (reset)
		(cpu_ce && cpu_rd && cpu_addr[15:14] == 2'b00) |-> (rom_addr[rom_word_w-1:13] == '0))
		else $error("rom_addr bank not zero for a read below 4000");

	a_regs_held: assert property (@(posedge clk_sys) disable iff (reset)
		dl_active |=> (rom_bank == 9'd1 && !ram_enable))   // regs parked during download
		else $error("controller registers left reset values during download");

endmodule

bind gb_cart_mapper gb_cart_mapper_assertions i_assertions (
	.clk_sys    (clk_sys),
	.reset      (reset),
	.dl_active  (dl_active),
	.cpu_ce     (cpu_ce),
	.cpu_rd     (cpu_rd),
	.cpu_addr   (cpu_addr),
	.cpu_rdata  (cpu_rdata),
	.rom_addr   (rom_addr),
	.rom_bank   (rom_bank),
	.ram_enable (ram_enable),
	.cart_ready (cart_ready)
);

// File: tb/tb_gb_cart_mapper.sv
/*
 * file driven testbench for the cartridge mapper, reads tb/cart_input.txt
 * run from the project root, inputs change on the falling clock edge
 * ROM model answers with the low 16 bits of rom_addr
 * a download ends at the first line that is not a D line
 */
`timescale 1ns/1ps

module tb_gb_cart_mapper
	import gb_cart_pkg::*;
	import gb_bus_pkg::*;
();

	localparam int ready_timeout = 16;             // cycles to wait for cart_ready

	logic                  clk_sys;
	logic                  reset;
	logic                  dl_active;
	logic                  dl_wr;
	logic [dl_addr_w-1:0]  dl_addr;
	logic [dl_data_w-1:0]  dl_data;
	logic                  cpu_ce;
	logic                  cpu_rd;
	logic                  cpu_wr;
	logic [cpu_addr_w-1:0] cpu_addr;
	logic [cpu_data_w-1:0] cpu_wdata;
	logic [cpu_data_w-1:0] cpu_rdata;
	logic [rom_word_w-1:0] rom_addr;
	logic [rom_data_w-1:0] rom_rdata;
	int                    errors;
	int                    tests;

	gb_cart_mapper i_dut (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_active (dl_active),
		.dl_wr     (dl_wr),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.cpu_ce    (cpu_ce),
		.cpu_rd    (cpu_rd),
		.cpu_wr    (cpu_wr),
		.cpu_addr  (cpu_addr),
		.cpu_wdata (cpu_wdata),
		.cpu_rdata (cpu_rdata),
		.rom_addr  (rom_addr),
		.rom_rdata (rom_rdata)
	);

	assign rom_rdata = rom_addr[15:0];             // ROM model, data is its own address

	always #5 clk_sys = ~clk_sys;                  // 100 MHz

	// ------------------------------------------------------------------
	// compare tasks
	task automatic check_byte(input string name, input logic [cpu_addr_w-1:0] addr,
		input logic [cpu_data_w-1:0] got, input logic [cpu_data_w-1:0] exp);
		tests++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s at %h: expected %h, got %h", name, addr, exp, got);
		end else begin
			$display("test %0d: %s at %h = %h", tests, name, addr, got);
		end
	endtask

	task automatic check_rom_addr(input string name, input logic [cpu_addr_w-1:0] addr,
		input logic [rom_word_w-1:0] got, input logic [rom_word_w-1:0] exp);
		tests++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s at %h: expected %h, got %h", name, addr, exp, got);
		end else begin
			$display("test %0d: %s at %h = %h", tests, name, addr, got);
		end
	endtask

	// ------------------------------------------------------------------
	// bus drivers
	task automatic download_word(input logic [dl_addr_w-1:0] addr,
		input logic [dl_data_w-1:0] data);
		@(negedge clk_sys);
		dl_active = 1'b1;                          // raised with the first word
		dl_wr     = 1'b1;
		dl_addr   = addr;
		dl_data   = data;
	endtask

	task automatic end_download(output bit stalled);
		int wait_cycles;
		@(negedge clk_sys);
		if (i_dut.cart_ready) begin                // must drop once a download starts
			errors++;
			$display("cart_ready stayed high while a download was running");
		end
		dl_wr       = 1'b0;
		dl_active   = 1'b0;
		wait_cycles = 0;
		while (!i_dut.cart_ready && wait_cycles < ready_timeout) begin
			@(negedge clk_sys);
			wait_cycles++;
		end
		stalled = !i_dut.cart_ready;
		if (stalled) begin
			errors++;
			$display("cart_ready did not rise within %0d cycles after the download",
				ready_timeout);
		end
	endtask

	task automatic cpu_write(input logic [cpu_addr_w-1:0] addr,
		input logic [cpu_data_w-1:0] data);
		@(negedge clk_sys);
		cpu_ce    = 1'b1;
		cpu_wr    = 1'b1;
		cpu_addr  = addr;
		cpu_wdata = data;
		@(negedge clk_sys);
		cpu_ce    = 1'b0;
		cpu_wr    = 1'b0;
	endtask

	task automatic cpu_read(input logic [cpu_addr_w-1:0] addr,
		output logic [cpu_data_w-1:0] data);
		@(negedge clk_sys);
		cpu_ce   = 1'b1;
		cpu_rd   = 1'b1;
		cpu_addr = addr;
		@(negedge clk_sys);                        // read edge has passed
		cpu_ce   = 1'b0;
		cpu_rd   = 1'b0;
		data     = cpu_rdata;
	endtask

	task automatic probe_rom_addr(input logic [cpu_addr_w-1:0] addr,
		output logic [rom_word_w-1:0] word);
		@(negedge clk_sys);
		cpu_addr = addr;                           // no strobe, address only
		@(negedge clk_sys);
		word     = rom_addr;
	endtask

	// ------------------------------------------------------------------
	// main sequence
	initial begin : run
		int                    fd;
		int                    code;
		logic [63:0]           op_word;
		logic [1023:0]         skip_line;
		logic [31:0]           field_a;
		logic [31:0]           field_b;
		logic [cpu_data_w-1:0] rd_byte;
		logic [rom_word_w-1:0] rd_word;
		bit                    done;

		clk_sys   = 1'b0;
		reset     = 1'b1;
		dl_active = 1'b0;
		dl_wr     = 1'b0;
		dl_addr   = '0;
		dl_data   = '0;
		cpu_ce    = 1'b0;
		cpu_rd    = 1'b0;
		cpu_wr    = 1'b0;
		cpu_addr  = '0;
		cpu_wdata = '0;
		errors    = 0;
		tests     = 0;
		done      = 1'b0;
		repeat (4) @(negedge clk_sys);
		reset = 1'b0;

		fd = $fopen("tb/cart_input.txt", "r");
		if (fd == 0) begin
			$display("cannot open tb/cart_input.txt");
			errors++;
			done = 1'b1;
		end

		while (!done) begin
			op_word = '0;
			code    = $fscanf(fd, "%s", op_word);
			if (code != 1) begin
				done = 1'b1;                       // end of file
			end else if (op_word[7:0] == "#") begin
				code = $fgets(skip_line, fd);      // comment line
			end else begin
				code = $fscanf(fd, "%h %h", field_a, field_b);
				if (code != 2) begin
					$display("input line for op %s has missing or bad hex fields", op_word);
					errors++;
					done = 1'b1;
				end else if (dl_active && op_word[7:0] != "D") begin
					end_download(done);
				end
				if (!done) begin
					case (op_word[7:0])
						"D": download_word(field_a[dl_addr_w-1:0], field_b[dl_data_w-1:0]);
						"W": cpu_write(field_a[cpu_addr_w-1:0], field_b[cpu_data_w-1:0]);
						"R": begin
							cpu_read(field_a[cpu_addr_w-1:0], rd_byte);
							check_byte("cpu_rdata", field_a[cpu_addr_w-1:0], rd_byte,
								field_b[cpu_data_w-1:0]);
						end
						"A": begin
							probe_rom_addr(field_a[cpu_addr_w-1:0], rd_word);
							check_rom_addr("rom_addr", field_a[cpu_addr_w-1:0], rd_word,
								field_b[rom_word_w-1:0]);
						end
						default: begin
							$display("unknown operation %s in the input file", op_word);
							errors++;
							done = 1'b1;
						end
					endcase
				end
			end
		end
		if (dl_active)
			end_download(done);                    // file ended inside a download
		if (fd != 0)
			$fclose(fd);

		$display("%0d tests, %0d errors", tests, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: src.f
verilog/gb_cart_pkg.sv
verilog/gb_bus_pkg.sv
verilog/cart_header_capture.sv
verilog/mbc_registers.sv
verilog/bank_mapper.sv
verilog/cart_ram_port.sv
verilog/gb_cart_mapper.sv
tb/gb_cart_mapper_assertions.sv
tb/tb_gb_cart_mapper.sv

// File: Makefile
# Verilator build and run of the cartridge mapper testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_gb_cart_mapper
FILELIST  := src.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := TEST FAILED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb/cart_input.txt
# columns: op addr value, hex. D = download word addr(24) data(16), W = cpu write
# R = cpu read addr, expected byte. A = cpu addr, expected rom_addr (22 bit)
R 4000 00
D 000146 0100
D 000148 0004
A 4000 002000
A 1234 00091a
R 1234 1a
W 2000 00
A 4000 002000
W 2000 25
A 4000 00a000
R 4002 01
R 4003 a0
D 000146 1900
D 000148 0008
W 2000 34
W 3000 01
A 4000 268000
A 5678 268b3c
R 5679 8b
D 000146 1300
D 000148 0302
R a000 ff
W 0000 0a
W a000 5a
R a000 5a
W 4000 01
W a000 c3
R a000 c3
W 4000 00
R a000 5a
W 4000 08
R a000 00
D 000146 0500
D 000148 0001
W 0000 0a
W a010 b7
R a010 f7
